//--- logic/apuPkg.sv
// ----------------------------------------------------------
// Pulse APU shared widths, register map, tables and the
// control byte union
// ----------------------------------------------------------
`default_nettype none

package apuPkg;

  // ----------------------------------------------------------
  // Widths
  localparam int AddrWidth   = 5;
  localparam int DataWidth   = 8;
  localparam int VolumeWidth = 4;
  localparam int PeriodWidth = 11;
  localparam int SampleWidth = 16;
  localparam int NumSquares  = 2;

  // Control register map, channel registers sit at 00h..07h
  localparam logic [AddrWidth-1:0] RegStatus = 5'h15;  // Enable write, status read
  localparam logic [AddrWidth-1:0] RegFrame  = 5'h17;  // Frame counter mode

  // Length load values, indexed by din[7:3] of a register 3 write
  localparam logic [7:0] lengthTable [32] = '{
    8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
  };

  // Nonlinear pulse DAC curve over the summed level 0..30
  localparam logic [SampleWidth-1:0] pulseMixTable [31] = '{
    16'd0,     16'd760,   16'd1503,  16'd2228,  16'd2936,  16'd3627,  16'd4303,  16'd4963,
    16'd5609,  16'd6240,  16'd6858,  16'd7462,  16'd8053,  16'd8631,  16'd9198,  16'd9752,
    16'd10296, 16'd10828, 16'd11349, 16'd11860, 16'd12361, 16'd12852, 16'd13334, 16'd13807,
    16'd14270, 16'd14725, 16'd15171, 16'd15609, 16'd16039, 16'd16461, 16'd16876
  };

  // ----------------------------------------------------------
  // One data byte, decoded as register 0 or register 1
  typedef union packed {
    struct packed {
      logic [1:0] duty;       // Duty select
      logic       loopHalt;   // Envelope loop and length halt share a bit
      logic       constVol;   // Constant volume instead of envelope
      logic [3:0] volume;     // Level or envelope divider period
    } dutyEnvView;
    struct packed {
      logic       enable;
      logic [2:0] period;     // Sweep divider period
      logic       negate;
      logic [2:0] shift;
    } sweepView;
  } squareCtrlU;

endpackage

`default_nettype wire

//--- logic/frameSequencer.sv
// ----------------------------------------------------------
// Frame sequencer: quarter/half frame ticks, timer tick and
// the frame interrupt flag in four- and five-step modes
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module frameSequencer #(
  parameter int StepCycles = 7457        // ce cycles per sequencer step
) (
  input  logic clk,
  input  logic reset,
  input  logic ce,
  input  logic frameWrite,               // Write strobe at the frame register
  input  logic statusRead,               // Status read, clears the flag
  input  logic modeIn,                   // 1 selects the five-step mode
  input  logic inhibitIn,                // Interrupt inhibit
  output logic quarterFrame,
  output logic halfFrame,
  output logic timerTick,
  output logic frameFlag,
  output logic frameIrq
);

  localparam int CountWidth = $clog2(StepCycles);

  logic [CountWidth-1:0] cycleCount;     // ce cycles within the step
  logic [2:0]            stepIdx;        // 0..3, or 0..4 in mode 1
  logic                  mode;
  logic                  inhibit;
  logic                  stepEnd;

  assign stepEnd  = (cycleCount == CountWidth'(StepCycles - 1));
  assign frameIrq = frameFlag & ~inhibit;

  // ----------------------------------------------------------
  // Step schedule
  always_ff @(posedge clk) begin
    if (reset) begin
      cycleCount   <= '0;
      stepIdx      <= 3'd0;
      mode         <= 1'b0;
      inhibit      <= 1'b0;
      frameFlag    <= 1'b0;
      quarterFrame <= 1'b0;
      halfFrame    <= 1'b0;
      timerTick    <= 1'b0;
    end else if (ce) begin
      quarterFrame <= 1'b0;                 // Pulses last one ce cycle
      halfFrame    <= 1'b0;
      timerTick    <= ~timerTick;           // Every second ce cycle
      cycleCount   <= cycleCount + 1'b1;
      if (statusRead)
        frameFlag <= 1'b0;                  // A set below still wins
      if (stepEnd) begin
        cycleCount <= '0;
        stepIdx    <= stepIdx + 3'd1;
        case (stepIdx)
          3'd0, 3'd2: quarterFrame <= 1'b1;
          3'd1: begin
            quarterFrame <= 1'b1;
            halfFrame    <= 1'b1;
          end
          3'd3: begin
            if (!mode) begin                // Last step of mode 0
              quarterFrame <= 1'b1;
              halfFrame    <= 1'b1;
              stepIdx      <= 3'd0;
              if (!inhibit)
                frameFlag <= 1'b1;
            end
          end
          default: begin                    // Step 4, mode 1 only
            quarterFrame <= 1'b1;
            halfFrame    <= 1'b1;
            stepIdx      <= 3'd0;
          end
        endcase
      end
      // Frame register write restarts the count
      if (frameWrite) begin
        mode         <= modeIn;
        inhibit      <= inhibitIn;
        cycleCount   <= '0;
        stepIdx      <= 3'd0;
        quarterFrame <= modeIn;             // Immediate clocks in mode 1
        halfFrame    <= modeIn;
        if (inhibitIn)
          frameFlag <= 1'b0;
      end
    end
  end

  // Half-frame clocks always come with a quarter-frame clock
  halfWithQuarter: assert property (@(posedge clk) disable iff (reset)
    halfFrame |-> quarterFrame);

endmodule

`default_nettype wire

//--- logic/squareChannel.sv
// ----------------------------------------------------------
// Pulse channel: registers, timer, duty sequencer, envelope,
// sweep and length counter
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module squareChannel #(
  parameter int ChannelIndex = 0           // 0 ones' complement negate, 1 two's
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           ce,
  input  logic                           write,        // Strobe for this channel
  input  logic [1:0]                     regSel,
  input  logic [apuPkg::DataWidth-1:0]   din,
  input  logic                           enable,
  input  logic                           quarterFrame,
  input  logic                           halfFrame,
  input  logic                           timerTick,
  output logic [apuPkg::VolumeWidth-1:0] level,
  output logic                           active
);
  import apuPkg::*;

  squareCtrlU ctrl;                        // Write data in both views

  logic [1:0]             duty;
  logic                   loopHalt;        // Envelope loop, length halt
  logic                   constVol;
  logic [VolumeWidth-1:0] volume;
  logic                   sweepEn;
  logic                   sweepNegate;
  logic                   sweepReload;     // Reload divider on next half frame
  logic [2:0]             sweepPeriod;
  logic [2:0]             sweepShift;
  logic [2:0]             sweepDivider;
  logic [PeriodWidth-1:0] period;
  logic [PeriodWidth-1:0] timer;
  logic [2:0]             seqPos;          // Duty step, counts down
  logic [7:0]             lenCnt;
  logic                   envStart;
  logic [VolumeWidth-1:0] envelope;
  logic [VolumeWidth-1:0] envDivider;

  logic [PeriodWidth-1:0] shifted;
  logic [PeriodWidth-1:0] sweepRhs;
  logic [PeriodWidth:0]   sweepTarget;     // Extra bit flags overflow
  logic                   sweepMute;
  logic                   dutyHigh;

  assign ctrl        = din;
  assign shifted     = period >> sweepShift;
  assign sweepRhs    = sweepNegate ? ~shifted + PeriodWidth'(ChannelIndex) : shifted;
  assign sweepTarget = {1'b0, period} + {1'b0, sweepRhs};
  assign sweepMute   = (period < PeriodWidth'(8)) || (!sweepNegate && sweepTarget[PeriodWidth]);

  // ----------------------------------------------------------
  // Output level
  always_comb begin
    case (duty)
      2'd0:    dutyHigh = (seqPos == 3'd7);  // 12.5 %
      2'd1:    dutyHigh = (seqPos >= 3'd6);  // 25 %
      2'd2:    dutyHigh = (seqPos >= 3'd4);  // 50 %
      default: dutyHigh = (seqPos < 3'd6);   // 25 % inverted
    endcase
  end

  assign active = (lenCnt != 8'd0);
  assign level  = (!active || sweepMute || !dutyHigh) ? '0 : (constVol ? volume : envelope);

  always_ff @(posedge clk) begin
    if (reset) begin
      duty         <= 2'd0;
      loopHalt     <= 1'b0;
      constVol     <= 1'b0;
      volume       <= '0;
      sweepEn      <= 1'b0;
      sweepNegate  <= 1'b0;
      sweepReload  <= 1'b0;
      sweepPeriod  <= 3'd0;
      sweepShift   <= 3'd0;
      sweepDivider <= 3'd0;
      period       <= '0;
      timer        <= '0;
      seqPos       <= 3'd0;
      lenCnt       <= 8'd0;
      envStart     <= 1'b0;
      envelope     <= '0;
      envDivider   <= '0;
    end else if (ce) begin
      // Period timer steps the duty sequence
      if (timerTick) begin
        if (timer == '0) begin
          timer  <= period;
          seqPos <= seqPos - 3'd1;
        end else
          timer <= timer - 1'b1;
      end
      // Envelope on quarter frames
      if (quarterFrame) begin
        if (envStart) begin
          envStart   <= 1'b0;
          envelope   <= '1;
          envDivider <= volume;
        end else if (envDivider == '0) begin
          envDivider <= volume;
          if (envelope != '0)
            envelope <= envelope - 1'b1;
          else if (loopHalt)
            envelope <= '1;                 // Loop back to 15
        end else
          envDivider <= envDivider - 1'b1;
      end
      // Length and sweep on half frames
      if (halfFrame) begin
        if (active && !loopHalt)
          lenCnt <= lenCnt - 8'd1;
        if (sweepDivider == 3'd0 || sweepReload) begin
          sweepDivider <= sweepPeriod;
          if (sweepDivider == 3'd0 && sweepEn && sweepShift != 3'd0 && !sweepMute)
            period <= sweepTarget[PeriodWidth-1:0];
        end else
          sweepDivider <= sweepDivider - 3'd1;
        sweepReload <= 1'b0;
      end

      // ----------------------------------------------------------
      // Register writes override the clocked updates
      if (write) begin
        case (regSel)
          2'd0: begin
            duty     <= ctrl.dutyEnvView.duty;
            loopHalt <= ctrl.dutyEnvView.loopHalt;
            constVol <= ctrl.dutyEnvView.constVol;
            volume   <= ctrl.dutyEnvView.volume;
          end
          2'd1: begin
            sweepEn     <= ctrl.sweepView.enable;
            sweepPeriod <= ctrl.sweepView.period;
            sweepNegate <= ctrl.sweepView.negate;
            sweepShift  <= ctrl.sweepView.shift;
            sweepReload <= 1'b1;
          end
          2'd2: period[7:0] <= din;         // Low period byte
          default: begin
            period[PeriodWidth-1:8] <= din[2:0];
            lenCnt   <= lengthTable[din[7:3]];
            envStart <= 1'b1;               // Envelope restarts at 15
            seqPos   <= 3'd0;
          end
        endcase
      end
      if (!enable)
        lenCnt <= 8'd0;                     // Disabled channel stays silent
    end
  end

  levelNeedsLength: assert property (@(posedge clk) disable iff (reset)
    (level != '0) |-> active);

endmodule

`default_nettype wire

//--- logic/pulseMixer.sv
// ----------------------------------------------------------
// Nonlinear pulse mixer, registered table lookup of the
// summed channel levels
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pulseMixer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [apuPkg::VolumeWidth-1:0] level0,
  input  logic [apuPkg::VolumeWidth-1:0] level1,
  output logic [apuPkg::SampleWidth-1:0] sample
);
  import apuPkg::*;

  logic [VolumeWidth:0] levelSum;          // 0..30

  assign levelSum = {1'b0, level0} + {1'b0, level1};

  // ----------------------------------------------------------
  // One clock of latency from level to sample
  always_ff @(posedge clk) begin
    if (reset)
      sample <= '0;
    else
      sample <= pulseMixTable[levelSum];
  end

  // Table covers sums up to 30 only
  sumInTable: assert property (@(posedge clk) disable iff (reset)
    levelSum <= 5'd30);

endmodule

`default_nettype wire

//--- logic/apuSquare.sv
// ----------------------------------------------------------
// Two-channel pulse APU top: register decode, enable and
// status, frame sequencer, channels and mixer
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module apuSquare #(
  parameter int StepCycles = 7457          // ce cycles per frame step
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           ce,
  input  logic                           write,
  input  logic                           read,
  input  logic [apuPkg::AddrWidth-1:0]   addr,
  input  logic [apuPkg::DataWidth-1:0]   din,
  output logic [apuPkg::DataWidth-1:0]   dout,
  output logic [apuPkg::SampleWidth-1:0] sample,
  output logic                           irq
);
  import apuPkg::*;

  logic [NumSquares-1:0]  enableReg;       // Channel enables
  logic [NumSquares-1:0]  chanWrite;
  logic [NumSquares-1:0]  active;          // Length counter nonzero
  logic [VolumeWidth-1:0] level [NumSquares];
  logic                   quarterFrame;
  logic                   halfFrame;
  logic                   timerTick;
  logic                   frameFlag;
  logic                   frameWrite;
  logic                   statusRead;

  assign frameWrite = write && (addr == RegFrame);
  assign statusRead = read && (addr == RegStatus);

  always_ff @(posedge clk) begin
    if (reset)
      enableReg <= '0;
    else if (ce && write && addr == RegStatus)
      enableReg <= din[NumSquares-1:0];
  end

  frameSequencer #(.StepCycles(StepCycles)) frameSeq (
    .clk(clk), .reset(reset), .ce(ce),
    .frameWrite(frameWrite), .statusRead(statusRead),
    .modeIn(din[7]), .inhibitIn(din[6]),          // Mode and inhibit bits
    .quarterFrame(quarterFrame), .halfFrame(halfFrame), .timerTick(timerTick),
    .frameFlag(frameFlag), .frameIrq(irq)
  );

  // ----------------------------------------------------------
  // Pulse channels, four registers each from address 00h
  for (genvar i = 0; i < NumSquares; i++) begin : gSquare
    assign chanWrite[i] = write && (addr[4:2] == 3'(i));
    squareChannel #(.ChannelIndex(i)) square (
      .clk(clk), .reset(reset), .ce(ce), .write(chanWrite[i]),
      .regSel(addr[1:0]), .din(din), .enable(enableReg[i]),
      .quarterFrame(quarterFrame), .halfFrame(halfFrame), .timerTick(timerTick),
      .level(level[i]), .active(active[i])
    );
  end

  pulseMixer mixer (
    .clk(clk), .reset(reset),
    .level0(level[0]), .level1(level[1]),
    .sample(sample)
  );

  // Status readback, same cycle
  always_comb begin
    dout = '0;
    if (statusRead) begin
      dout[6]              = frameFlag;
      dout[NumSquares-1:0] = active;
    end
  end

endmodule

`default_nettype wire

//--- bench/apuSquareTasks.svh
// ----------------------------------------------------------
// Bus tasks, check helpers and directed tests for the APU
// ----------------------------------------------------------
`ifndef APU_SQUARE_TASKS_SVH
`define APU_SQUARE_TASKS_SVH
`default_nettype none

  // ----------------------------------------------------------
  // Bus and timing helpers
  function automatic logic [AddrWidth-1:0] regAddr(input int chan, input int sel);
    return AddrWidth'(chan * 4 + sel);      // Four registers per channel
  endfunction

  task automatic writeReg(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] d);
    @(negedge clk);
    addr  = a;
    din   = d;
    write = 1'b1;                           // Taken at the next rising edge
    @(negedge clk);
    write = 1'b0;
  endtask

  task automatic readStatus(output logic [DataWidth-1:0] value);
    @(negedge clk);
    addr = RegStatus;
    read = 1'b1;
    #(ClkPeriod / 2 - 1);                   // Settled, just before the clearing edge
    value = dout;
    @(negedge clk);
    read = 1'b0;
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic waitUntilCycle(input int target);
    while (cycleNum < target)
      @(negedge clk);
  endtask

  // Check helpers
  function automatic void noteError();
    errorCount++;
    testErrors++;
  endfunction

  task automatic checkEqual(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("FAIL %s %s: expected %0h, actual %0h", testName, what, expected, actual);
      noteError();
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    assert (cond === 1'b1)
    else begin
      $display("%s: %s", testName, what);
      noteError();
    end
  endtask

  task automatic startTest(input string name);
    testName   = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    testsRun++;
    if (testErrors == 0)
      $display("test %s: passed", testName);
    else begin
      testsFailed++;
      $display("test %s: %0d checks failed", testName, testErrors);
    end
  endtask

  // ----------------------------------------------------------
  // Directed tests
  task automatic resetStateTest();
    logic [DataWidth-1:0] status;
    startTest("reset state");
    readStatus(status);
    checkEqual("status", 8'h00, status);
    checkEqual("irq", 0, irq);
    checkEqual("sample", 0, sample);
    endTest();
  endtask

  task automatic lengthEnableTest();
    logic [DataWidth-1:0] status;
    startTest("length load and enable");
    writeReg(RegFrame, 8'h40);              // Mode 0, irq inhibited
    writeReg(RegStatus, 8'h03);
    writeReg(regAddr(0, 0), 8'h20);         // Length halt set
    writeReg(regAddr(0, 3), 8'h08);         // Length index 1
    readStatus(status);
    checkEqual("status after load", 8'h01, status);
    writeReg(RegStatus, 8'h00);             // Disable clears both lengths
    readStatus(status);
    checkEqual("status after disable", 8'h00, status);
    endTest();
  endtask

  task automatic lengthCountdownTest();
    logic [DataWidth-1:0] status;
    int                   frameStart;
    startTest("length countdown");
    writeReg(RegFrame, 8'h40);              // Restart, half frames at 2S and 4S
    frameStart = cycleNum;
    writeReg(RegStatus, 8'h01);
    writeReg(regAddr(0, 0), 8'h00);         // Halt clear
    writeReg(regAddr(0, 3), 8'h18);         // Index 3, two half frames long
    waitUntilCycle(frameStart + 2 * StepCycles - 4);
    readStatus(status);
    checkEqual("status before 2S", 8'h01, status);
    waitUntilCycle(frameStart + 3 * StepCycles);
    readStatus(status);
    checkEqual("status at 3S", 8'h01, status);
    waitUntilCycle(frameStart + 4 * StepCycles + 4);
    readStatus(status);
    checkEqual("status after 4S", 8'h00, status);
    endTest();
  endtask

  task automatic constantToneTest();
    logic sawZero;
    logic sawTone;
    startTest("constant volume tone");
    sawZero = 1'b0;
    sawTone = 1'b0;
    writeReg(RegStatus, 8'h02);             // Channel 1 only
    writeReg(regAddr(1, 0), 8'hB9);         // Duty 2, halt, constant volume 9
    writeReg(regAddr(1, 1), 8'h00);         // Sweep off
    writeReg(regAddr(1, 2), 8'd20);
    writeReg(regAddr(1, 3), 8'h08);
    repeat (400) begin
      @(negedge clk);
      assert (sample == 16'd0 || sample == pulseMixTable[9])
      else begin
        $display("FAIL %s sample: expected 0 or %0h, actual %0h",
                 testName, pulseMixTable[9], sample);
        noteError();
      end
      if (sample == 16'd0)
        sawZero = 1'b1;
      else
        sawTone = 1'b1;
    end
    checkTrue(sawZero, "sample never dropped to 0 during the tone");
    checkTrue(sawTone, "sample never reached the level 9 value");
    writeReg(regAddr(1, 2), 8'd5);          // Period below 8 mutes
    waitCycles(2);
    repeat (100) begin
      @(negedge clk);
      checkEqual("sample at period 5", 0, sample);
    end
    writeReg(RegStatus, 8'h00);
    endTest();
  endtask

  task automatic frameIrqTest();
    logic [DataWidth-1:0] status;
    int                   waited;
    logic                 sawIrq;
    startTest("frame interrupt");
    writeReg(RegFrame, 8'h40);              // Clear any old flag
    writeReg(RegFrame, 8'h00);              // Mode 0, irq allowed
    waited = 0;
    while (!irq && waited < 4 * StepCycles + 2) begin
      @(negedge clk);
      waited++;
    end
    checkTrue(irq, "irq did not rise within 4S plus 2 cycles in mode 0");
    readStatus(status);
    checkEqual("status with flag", 8'h40, status);
    readStatus(status);
    checkEqual("status after clear", 8'h00, status);
    checkEqual("irq after clear", 0, irq);
    writeReg(RegFrame, 8'h80);              // Five-step mode, no flag
    sawIrq = 1'b0;
    repeat (10 * StepCycles) begin
      @(negedge clk);
      if (irq)
        sawIrq = 1'b1;
    end
    checkTrue(!sawIrq, "irq rose in five-step mode");
    endTest();
  endtask

  task automatic envelopeDecayTest();
    logic [SampleWidth-1:0] lastTone;
    logic                   sawTone;
    int                     frameStart;
    startTest("envelope decay");
    lastTone = '1;
    sawTone  = 1'b0;
    writeReg(RegFrame, 8'h40);              // Quarter frames every S from here
    frameStart = cycleNum;
    writeReg(RegStatus, 8'h01);
    writeReg(regAddr(0, 0), 8'hC0);         // Duty 3, envelope period 0, no loop
    writeReg(regAddr(0, 1), 8'h00);
    writeReg(regAddr(0, 2), 8'd20);
    writeReg(regAddr(0, 3), 8'h08);         // Long length, envelope restart
    while (cycleNum < frameStart + 16 * StepCycles + 4) begin
      @(negedge clk);
      if (sample != 16'd0) begin
        assert (sample <= lastTone)
        else begin
          $display("FAIL %s decay: expected at most %0h, actual %0h",
                   testName, lastTone, sample);
          noteError();
        end
        lastTone = sample;
        sawTone  = 1'b1;
      end
    end
    checkTrue(sawTone, "envelope never produced a nonzero sample");
    repeat (2 * StepCycles) begin           // Envelope has reached 0
      @(negedge clk);
      checkEqual("sample after decay", 0, sample);
    end
    writeReg(RegStatus, 8'h00);
    endTest();
  endtask

`default_nettype wire
`endif

//--- bench/apuSquareTb.sv
// ----------------------------------------------------------
// Testbench for the two-channel pulse APU: clock, reset,
// watchdog and the directed test sequence
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module apuSquareTb;
  import apuPkg::*;

  localparam int ClkPeriod   = 10;
  localparam int StepCycles  = 16;         // Short frame steps
  localparam int ResetCycles = 4;
  localparam int BusCycles   = 100;        // All register writes and reads

  // ----------------------------------------------------------
  // Longest waits per test, in clock cycles
  localparam int LengthWait   = 4 * StepCycles + 4;
  localparam int ToneWait     = 500;       // 400 tone cycles plus 100 muted
  localparam int IrqWait      = (4 * StepCycles + 2) + 10 * StepCycles;
  localparam int EnvelopeWait = 18 * StepCycles + 4;
  localparam int TestWaitCycles = ResetCycles + LengthWait + ToneWait + IrqWait
                                + EnvelopeWait + BusCycles;
  localparam int WatchdogCycles = 2 * TestWaitCycles;

  logic                   clk;
  logic                   reset;
  logic                   ce;
  logic                   write;
  logic                   read;
  logic [AddrWidth-1:0]   addr;
  logic [DataWidth-1:0]   din;
  logic [DataWidth-1:0]   dout;
  logic [SampleWidth-1:0] sample;
  logic                   irq;

  int    cycleNum;                         // Rising edges since time zero
  int    errorCount;
  int    testErrors;                       // Failed checks in the running test
  int    testsRun;
  int    testsFailed;
  string testName;

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk)
    cycleNum <= cycleNum + 1;

  apuSquare #(.StepCycles(StepCycles)) dut (
    .clk(clk), .reset(reset), .ce(ce),
    .write(write), .read(read),
    .addr(addr), .din(din), .dout(dout),
    .sample(sample), .irq(irq)
  );

  // ----------------------------------------------------------
  // Watchdog
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
    $display("=== FAIL ===");
    $finish;
  end

  // ----------------------------------------------------------
  // Test sequence
  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    ce          = 1'b1;                    // Every cycle enabled
    write       = 1'b0;
    read        = 1'b0;
    addr        = '0;
    din         = '0;
    cycleNum    = 0;
    errorCount  = 0;
    testErrors  = 0;
    testsRun    = 0;
    testsFailed = 0;
    testName    = "";
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;

    resetStateTest();
    lengthEnableTest();
    lengthCountdownTest();
    constantToneTest();
    frameIrqTest();
    envelopeDecayTest();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  `include "apuSquareTasks.svh"

endmodule

`default_nettype wire

//--- apuSquare.f
+incdir+bench
logic/apuPkg.sv
logic/frameSequencer.sv
logic/squareChannel.sv
logic/pulseMixer.sv
logic/apuSquare.sv
bench/apuSquareTb.sv

//--- run.sh
#!/bin/sh
# Build the pulse APU testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module apuSquareTb \
  --Mdir "$BUILD_DIR" -o apuSquareSim \
  -f apuSquare.f

if ! "./$BUILD_DIR/apuSquareSim" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation aborted"
  exit 1
fi
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
